/* common/fcl_pkg.sv */
// fcl shared package with the sizes and payload types of the fully connected layer
package fcl_pkg;

   // pixel and weight sizes
   localparam int PXL_WIDTH             = 8;
   localparam int WEIGHT_WIDTH          = 8;

   // filter window is 5 rows of 5 weights
   localparam int NUM_FILT_ROWS         = 5;
   localparam int NUM_WGHT_PER_FILT_ROW = 5;

   // weight sram, one row per filter row
   localparam int SRAM_DEPTH            = 5;
   localparam int SRAM_ADDRW            = 3;
   // five weights side by side
   localparam int SRAM_WIDTH            = NUM_WGHT_PER_FILT_ROW * WEIGHT_WIDTH;

   // 8x8 unsigned product
   localparam int PROD_WIDTH            = PXL_WIDTH + WEIGHT_WIDTH;
   // five products need 3 extra bits
   localparam int ROW_SUM_WIDTH         = PROD_WIDTH + 3;
   // 25 products, max 25*255*255 still fits in 21 bits
   localparam int FCL_SUM_WIDTH         = 21;

   // one window row of pixels, pixel 0 in the low byte
   typedef logic [NUM_WGHT_PER_FILT_ROW-1:0][PXL_WIDTH-1:0] pxl_row_t;

   // full 5x5 pixel window
   typedef pxl_row_t [NUM_FILT_ROWS-1:0] pxl_mat_t;

   // one weight row as stored in the sram
   typedef logic [SRAM_WIDTH-1:0] sram_row_t;

   // all weight rows held in registers
   typedef sram_row_t [NUM_FILT_ROWS-1:0] wght_mat_t;

   typedef logic [SRAM_ADDRW-1:0] sram_addr_t;

   // datapath widths through the adder tree
   typedef logic [PROD_WIDTH-1:0]    prod_t;
   typedef logic [ROW_SUM_WIDTH-1:0] row_sum_t;
   typedef logic [FCL_SUM_WIDTH-1:0] fcl_sum_t;

endpackage

/* fcl_compute/parl_add_5.sv */
// five input parallel adder with registered sum and valid, operand and sum types set per instance
module parl_add_5 #(
   parameter type operand_t = logic [7:0],
   parameter type sum_t     = logic [10:0]
) (
   input  logic            parl_add_clk_i,
   input  logic            rst_n_i,
   input  logic            valid_i,
   input  operand_t [4:0]  in_i,
   output logic            valid_o,
   output sum_t            sum_o
);

   sum_t  sum_d;

   // widen every operand first so no carry is lost
   always_comb begin
      sum_d = '0;
      for (int i = 0; i < 5; i++) begin
         sum_d = sum_d + sum_t'(in_i[i]);
      end
   end

   always_ff @(posedge parl_add_clk_i) begin
      if (!rst_n_i) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= valid_i;
      end
   end

   // sum only updates with valid data
   always_ff @(posedge parl_add_clk_i) begin
      if (valid_i) begin
         sum_o <= sum_d;
      end
   end

endmodule

/* fcl_compute/fcl_mac_pipe.sv */
// fcl mac pipeline, 25 products reduced by a two level tree of 5 input adders
module fcl_mac_pipe (
   input  logic                fcl_mac_clk_i,
   input  logic                rst_n_i,
   input  logic                pxl_valid_i,
   input  fcl_pkg::pxl_mat_t   pxl_mat_i,
   input  logic                wght_ready_i,
   input  fcl_pkg::wght_mat_t  wght_mat_i,
   output logic                sum_valid_o,
   output fcl_pkg::fcl_sum_t   sum_o
);

   // accepted pixel window
   logic  pxl_acc;

   // stage 1, products indexed [row][pixel]
   fcl_pkg::prod_t [fcl_pkg::NUM_FILT_ROWS-1:0][fcl_pkg::NUM_WGHT_PER_FILT_ROW-1:0] prod_q;
   logic  prod_vld_q;

   // stage 2, one sum per window row
   fcl_pkg::row_sum_t [fcl_pkg::NUM_FILT_ROWS-1:0] row_sum;
   logic [fcl_pkg::NUM_FILT_ROWS-1:0] row_vld;

   // windows arriving while weights load are dropped
   assign pxl_acc = pxl_valid_i & wght_ready_i;

   always_ff @(posedge fcl_mac_clk_i) begin
      if (!rst_n_i) begin
         prod_vld_q <= 1'b0;
      end else begin
         prod_vld_q <= pxl_acc;
      end
   end

   // weight byte j of row r times pixel j of row r
   always_ff @(posedge fcl_mac_clk_i) begin
      if (pxl_acc) begin
         for (int r = 0; r < fcl_pkg::NUM_FILT_ROWS; r++) begin
            for (int j = 0; j < fcl_pkg::NUM_WGHT_PER_FILT_ROW; j++) begin
               prod_q[r][j] <= pxl_mat_i[r][j] *
                               wght_mat_i[r][j*fcl_pkg::WEIGHT_WIDTH +: fcl_pkg::WEIGHT_WIDTH];
            end
         end
      end
   end

   // first tree level
   for (genvar r = 0; r < fcl_pkg::NUM_FILT_ROWS; r++) begin : g_row_add
      parl_add_5 #(
         .operand_t  (fcl_pkg::prod_t),
         .sum_t      (fcl_pkg::row_sum_t)
      ) row_add_inst (
         .parl_add_clk_i  (fcl_mac_clk_i),
         .rst_n_i         (rst_n_i),
         .valid_i         (prod_vld_q),
         .in_i            (prod_q[r]),
         .valid_o         (row_vld[r]),
         .sum_o           (row_sum[r])
      );
   end

   // second tree level gives the dot product
   // row valids all move together
   parl_add_5 #(
      .operand_t  (fcl_pkg::row_sum_t),
      .sum_t      (fcl_pkg::fcl_sum_t)
   ) final_add_inst (
      .parl_add_clk_i  (fcl_mac_clk_i),
      .rst_n_i         (rst_n_i),
      .valid_i         (&row_vld),
      .in_i            (row_sum),
      .valid_o         (sum_valid_o),
      .sum_o           (sum_o)
   );

endmodule

/* weights/weight_bank.sv */
// weight bank, sram with external write port and a read path that fills the weight row registers
module weight_bank (
   input  logic                 wght_clk_i,
   input  logic                 rst_n_i,
   input  logic                 wr_en_i,
   input  fcl_pkg::sram_addr_t  wr_addr_i,
   input  fcl_pkg::sram_row_t   wr_data_i,
   input  logic                 rd_en_i,
   input  fcl_pkg::sram_addr_t  rd_addr_i,
   output fcl_pkg::wght_mat_t   wght_mat_o
);

   // weight storage, one row per filter row
   fcl_pkg::sram_row_t   mem [fcl_pkg::SRAM_DEPTH];

   // sram read data register
   fcl_pkg::sram_row_t   rd_data_q;

   // read request delayed to line up with rd_data_q
   logic                 rd_en_q;
   fcl_pkg::sram_addr_t  rd_addr_q;

   // write port
   always_ff @(posedge wght_clk_i) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // synchronous read, data one cycle after the address
   always_ff @(posedge wght_clk_i) begin
      if (rd_en_i) begin
         rd_data_q <= mem[rd_addr_i];
      end
   end

   always_ff @(posedge wght_clk_i) begin
      if (!rst_n_i) begin
         rd_en_q <= 1'b0;
      end else begin
         rd_en_q <= rd_en_i;
      end
   end

   always_ff @(posedge wght_clk_i) begin
      rd_addr_q <= rd_addr_i;
   end

   // copy the returning row into its register
   // sram writes never touch these, only a load does
   always_ff @(posedge wght_clk_i) begin
      if (!rst_n_i) begin
         wght_mat_o <= '0;
      end else if (rd_en_q) begin
         wght_mat_o[rd_addr_q] <= rd_data_q;
      end
   end

endmodule

/* weights/fcl_load_ctrl.sv */
// fcl load controller, fsm that copies the weight sram into the weight registers on wake or restart
module fcl_load_ctrl (
   input  logic                 fcl_ctrl_clk_i,
   input  logic                 rst_n_i,
   input  logic                 wake_i,
   input  logic                 restart_i,
   output logic                 sram_rd_en_o,
   output fcl_pkg::sram_addr_t  sram_rd_addr_o,
   output logic                 wght_ready_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_LOAD,
      ST_READY
   } state_t;

   state_t               state_q;
   state_t               state_d;

   // row counter, runs 0..6 during a load
   fcl_pkg::sram_addr_t  row_cnt_q;
   logic                 load_last;

   // 5 read cycles, 1 cycle for the last row to land, 1 settle cycle
   assign load_last = (row_cnt_q == fcl_pkg::sram_addr_t'(fcl_pkg::SRAM_DEPTH + 1));

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            // wake only counts while idle
            if (wake_i) begin
               state_d = ST_LOAD;
            end
         end
         ST_LOAD: begin
            if (load_last) begin
               state_d = ST_READY;
            end
         end
         ST_READY: begin
            // restart reloads from the sram
            if (restart_i) begin
               state_d = ST_LOAD;
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge fcl_ctrl_clk_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // counter parked at zero outside a load
   always_ff @(posedge fcl_ctrl_clk_i) begin
      if (!rst_n_i) begin
         row_cnt_q <= '0;
      end else if (state_q != ST_LOAD) begin
         row_cnt_q <= '0;
      end else begin
         row_cnt_q <= row_cnt_q + 1'b1;
      end
   end

   // reads only for the first five load cycles
   assign sram_rd_en_o   = (state_q == ST_LOAD) && (row_cnt_q < fcl_pkg::SRAM_DEPTH);
   assign sram_rd_addr_o = row_cnt_q;

   assign wght_ready_o   = (state_q == ST_READY);

endmodule

/* src/fcl1_top.sv */
// fcl1 top level, weight load controller plus weight bank plus mac pipeline
module fcl1_top (
   input  logic                 fcl1_top_clk_i,
   input  logic                 rst_n_i,
   input  logic                 fcl1_top_wake_i,
   input  logic                 fcl1_top_restart_i,
   // external weight write port
   input  logic                 wght_wr_en_i,
   input  fcl_pkg::sram_addr_t  wght_wr_addr_i,
   input  fcl_pkg::sram_row_t   wght_wr_data_i,
   // pixel window with its valid strobe
   input  logic                 fcl_pixel_valid_i,
   input  fcl_pkg::pxl_mat_t    fcl_pixel_data_i,
   output logic                 fcl_ready_o,
   output logic                 fcl_result_valid_o,
   output fcl_pkg::fcl_sum_t    fcl_result_o
);

   // controller to weight bank
   logic                 sram_rd_en;
   fcl_pkg::sram_addr_t  sram_rd_addr;

   // weights ready, shared by the mac and the ready output
   logic                 wght_ready;

   // weight registers into the mac
   fcl_pkg::wght_mat_t   wght_mat;

   assign fcl_ready_o = wght_ready;

   // wake/restart sequencing and sram read addresses
   fcl_load_ctrl fcl_load_ctrl_inst (
      .fcl_ctrl_clk_i  (fcl1_top_clk_i),
      .rst_n_i         (rst_n_i),
      .wake_i          (fcl1_top_wake_i),
      .restart_i       (fcl1_top_restart_i),
      .sram_rd_en_o    (sram_rd_en),
      .sram_rd_addr_o  (sram_rd_addr),
      .wght_ready_o    (wght_ready)
   );

   // sram and weight row registers
   weight_bank weight_bank_inst (
      .wght_clk_i  (fcl1_top_clk_i),
      .rst_n_i     (rst_n_i),
      .wr_en_i     (wght_wr_en_i),
      .wr_addr_i   (wght_wr_addr_i),
      .wr_data_i   (wght_wr_data_i),
      .rd_en_i     (sram_rd_en),
      .rd_addr_i   (sram_rd_addr),
      .wght_mat_o  (wght_mat)
   );

   // 25 multiplies and the two level adder tree
   fcl_mac_pipe fcl_mac_pipe_inst (
      .fcl_mac_clk_i  (fcl1_top_clk_i),
      .rst_n_i        (rst_n_i),
      .pxl_valid_i    (fcl_pixel_valid_i),
      .pxl_mat_i      (fcl_pixel_data_i),
      .wght_ready_i   (wght_ready),
      .wght_mat_i     (wght_mat),
      .sum_valid_o    (fcl_result_valid_o),
      .sum_o          (fcl_result_o)
   );

endmodule

/* test/fcl1_checker.sv */
// fcl1 checker, compares each result pulse with the queued expected sums in order
module fcl1_checker (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               ready_i,
   input  logic               result_valid_i,
   input  fcl_pkg::fcl_sum_t  result_i
);

   // expected sums and the edge count at which each is due
   fcl_pkg::fcl_sum_t  exp_q [$];
   int                 due_q [$];
   int                 cyc = 0;

   string  test_name = "";
   int     test_checks = 0;
   int     test_errors = 0;
   int     tests_run = 0;
   int     tests_failed = 0;
   int     total_checks = 0;
   int     total_errors = 0;

   always @(posedge clk_i) begin
      cyc <= cyc + 1;
   end

   function automatic int pending();
      return exp_q.size();
   endfunction

   task automatic count_check(logic ok);
      test_checks++;
      total_checks++;
      if (!ok) begin
         test_errors++;
         total_errors++;
      end
   endtask

   task automatic report_failure(string msg);
      $display("test %s: %s", test_name, msg);
      count_check(1'b0);
   endtask

   task automatic check_value(string what, int expected, int actual);
      if (expected != actual) begin
         $display("** Error test %s: %s expected %0d actual %0d",
                  test_name, what, expected, actual);
      end
      count_check(expected == actual);
   endtask

   task automatic check_ready(logic expected);
      check_value("ready", int'(expected), int'(ready_i));
   endtask

   // valid taken on the next edge, result out two edges after that
   task automatic push_expected(fcl_pkg::fcl_sum_t value);
      exp_q.push_back(value);
      due_q.push_back(cyc + 3);
   endtask

   task automatic begin_test(string name);
      test_name   = name;
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s: passed, %0d checks", test_name, test_checks);
      end else begin
         tests_failed++;
         $display("test %s: failed, %0d of %0d checks wrong",
                  test_name, test_errors, test_checks);
      end
   endtask

   task automatic report_counts();
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, total_checks, total_errors);
   endtask

   // outputs are stable at the falling edge
   always @(negedge clk_i) begin
      if (rst_n_i) begin
         if (result_valid_i) begin
            if (exp_q.size() == 0) begin
               report_failure("result valid while no result was expected");
            end else begin
               check_value("result cycle", due_q[0], cyc);
               if (result_i !== exp_q[0]) begin
                  $display("** Error test %s: result expected %0d actual %0d",
                           test_name, exp_q[0], result_i);
               end
               count_check(result_i === exp_q[0]);
               void'(exp_q.pop_front());
               void'(due_q.pop_front());
            end
         end else if (exp_q.size() != 0 && cyc > due_q[0]) begin
            // head is overdue, count it missing so later ones still line up
            report_failure($sformatf("missing result, expected sum %0d never came",
                                     exp_q[0]));
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
         end
      end
   end

endmodule

/* test/fcl1_tb.sv */
// fcl1 testbench top, runs the trace file against the fully connected layer
module fcl1_tb;

   logic                 clk;
   logic                 rst_n;
   logic                 wake;
   logic                 restart;
   logic                 wr_en;
   fcl_pkg::sram_addr_t  wr_addr;
   fcl_pkg::sram_row_t   wr_data;
   logic                 pxl_valid;
   fcl_pkg::pxl_mat_t    pxl_data;
   logic                 ready;
   logic                 result_valid;
   fcl_pkg::fcl_sum_t    result;

   // whole trace, read before reset is released
   string        trace_q [$];
   int           cycles = 0;
   int           cycle_limit = 0;
   // cycle count when the last wake or restart went out
   int           load_start = 0;
   logic         in_test = 1'b0;
   logic [31:0]  rnd_state = 32'd92384;

   fcl1_top dut (
      .fcl1_top_clk_i      (clk),
      .rst_n_i             (rst_n),
      .fcl1_top_wake_i     (wake),
      .fcl1_top_restart_i  (restart),
      .wght_wr_en_i        (wr_en),
      .wght_wr_addr_i      (wr_addr),
      .wght_wr_data_i      (wr_data),
      .fcl_pixel_valid_i   (pxl_valid),
      .fcl_pixel_data_i    (pxl_data),
      .fcl_ready_o         (ready),
      .fcl_result_valid_o  (result_valid),
      .fcl_result_o        (result)
   );

   fcl1_checker chk (
      .clk_i           (clk),
      .rst_n_i         (rst_n),
      .ready_i         (ready),
      .result_valid_i  (result_valid),
      .result_i        (result)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

   // run limit, armed once the trace length is known
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout, the run is still going after %0d cycles", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // idle gap of 0 to 3 cycles
   task automatic random_gap();
      rnd_state = xorshift32(rnd_state);
      repeat (rnd_state[1:0]) @(negedge clk);
   endtask

   task automatic write_row(fcl_pkg::sram_addr_t addr, fcl_pkg::sram_row_t data);
      wr_en   = 1'b1;
      wr_addr = addr;
      wr_data = data;
      @(negedge clk);
      wr_en   = 1'b0;
   endtask

   // one cycle wake or restart strobe
   task automatic pulse_load(logic is_restart);
      wake       = !is_restart;
      restart    = is_restart;
      load_start = cycles;
      @(negedge clk);
      wake       = 1'b0;
      restart    = 1'b0;
   endtask

   // strobe taken on the next edge, ready 7 edges after that
   task automatic wait_ready();
      while (!ready) @(negedge clk);
      chk.check_value("ready delay", 8, cycles - load_start);
   endtask

   task automatic send_vector(fcl_pkg::pxl_mat_t data, logic accepted,
                              fcl_pkg::fcl_sum_t expected);
      chk.check_ready(accepted);
      pxl_valid = 1'b1;
      pxl_data  = data;
      if (accepted) begin
         chk.push_expected(expected);
      end
      @(negedge clk);
      pxl_valid = 1'b0;
   endtask

   // wait out the pipeline, then a few idle cycles for stray results
   task automatic drain_results();
      while (chk.pending() != 0) @(negedge clk);
      repeat (4) @(negedge clk);
   endtask

   task automatic run_line(string line);
      string                cmd;
      string                name;
      int                   num;
      fcl_pkg::sram_addr_t  addr;
      fcl_pkg::sram_row_t   row;
      fcl_pkg::pxl_mat_t    vec;
      fcl_pkg::fcl_sum_t    sum;
      cmd = "";
      void'($sscanf(line, "%s", cmd));
      case (cmd)
         "T": begin
            void'($sscanf(line, "%s %s", cmd, name));
            if (in_test) begin
               drain_results();
               chk.end_test();
            end
            chk.begin_test(name);
            in_test = 1'b1;
         end
         "W": begin
            void'($sscanf(line, "%s %h %h", cmd, addr, row));
            write_row(addr, row);
         end
         "K": pulse_load(1'b0);
         "R": pulse_load(1'b1);
         "Y": wait_ready();
         // ready must stay low while idling here
         "L": begin
            void'($sscanf(line, "%s %d", cmd, num));
            repeat (num) begin
               chk.check_ready(1'b0);
               @(negedge clk);
            end
         end
         "P", "S": begin
            void'($sscanf(line, "%s %h %h", cmd, vec, sum));
            if (cmd == "P") begin
               random_gap();
            end
            send_vector(vec, 1'b1, sum);
         end
         "N": begin
            void'($sscanf(line, "%s %h", cmd, vec));
            send_vector(vec, 1'b0, '0);
         end
         default: begin
            if (cmd != "" && cmd.substr(0, 0) != "#") begin
               chk.report_failure({"unknown trace command ", cmd});
            end
         end
      endcase
   endtask

   initial begin
      int     fd;
      string  line;
      rst_n     = 1'b0;
      wake      = 1'b0;
      restart   = 1'b0;
      wr_en     = 1'b0;
      wr_addr   = '0;
      wr_data   = '0;
      pxl_valid = 1'b0;
      pxl_data  = '0;
      fd = $fopen("test/fcl1_trace.txt", "r");
      if (fd == 0) begin
         $display("cannot open the trace file test/fcl1_trace.txt");
         $display("TEST FAILED");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
               trace_q.push_back(line);
            end
         end
         $fclose(fd);
         cycle_limit = trace_q.size() * 16 + 100;
         repeat (8) @(negedge clk);
         rst_n = 1'b1;
         foreach (trace_q[i]) begin
            run_line(trace_q[i]);
         end
         if (in_test) begin
            drain_results();
            chk.end_test();
         end
         chk.report_counts();
         if (chk.total_errors == 0) begin
            $display("TEST OK");
         end else begin
            $display("TEST FAILED");
         end
         $finish;
      end
   end

endmodule

/* test/fcl1_trace.txt */
# T name | W addr row | K wake | R restart | Y wait ready | L n idle cycles with ready low
# P pixels sum, random gap | S pixels sum, no gap | N pixels sent while not ready (hex)
T reset_state
L 10
N 01010101010101010101010101010101010101010101010101
W 0 0102030405
W 1 0102030405
W 2 0102030405
W 3 0102030405
W 4 0102030405
K
Y
P 01010101010101010101010101010101010101010101010101 4b
T streaming
S 01010101010101010101010101010101010101010101010101 4b
S 02020202020202020202020202020202020202020202020202 96
S 10101010101010101010101010101010101010101010101010 4b0
S 05050505050404040404030303030302020202020101010101 e1
S 0a0b0c0d0e0a0b0c0d0e0a0b0c0d0e0a0b0c0d0e0a0b0c0d0e 3b6
S 02020202020202020202020202020202020202020202020202 96
T not_ready
R
N 02020202020202020202020202020202020202020202020202
N 10101010101010101010101010101010101010101010101010
Y
P 01010101010101010101010101010101010101010101010101 4b
T reload_on_restart
W 0 0101010101
W 1 0101010101
W 2 0101010101
W 3 0101010101
W 4 0101010101
P 05050505050404040404030303030302020202020101010101 e1
P 0a0b0c0d0e0a0b0c0d0e0a0b0c0d0e0a0b0c0d0e0a0b0c0d0e 3b6
R
Y
P 05050505050404040404030303030302020202020101010101 4b
P 0a0b0c0d0e0a0b0c0d0e0a0b0c0d0e0a0b0c0d0e0a0b0c0d0e 12c
T full_scale
W 0 ffffffffff
W 1 ffffffffff
W 2 ffffffffff
W 3 ffffffffff
W 4 ffffffffff
R
Y
P ffffffffffffffffffffffffffffffffffffffffffffffffff 18ce19
S ffffffffffffffffffffffffffffffffffffffffffffffffff 18ce19
T zero_weights
W 0 0000000000
W 1 0000000000
W 2 0000000000
W 3 0000000000
W 4 0000000000
R
Y
P ffffffffffffffffffffffffffffffffffffffffffffffffff 0
P 10101010101010101010101010101010101010101010101010 0

/* fcl1_top.f */
common/fcl_pkg.sv
fcl_compute/parl_add_5.sv
fcl_compute/fcl_mac_pipe.sv
weights/weight_bank.sv
weights/fcl_load_ctrl.sv
src/fcl1_top.sv
test/fcl1_checker.sv
test/fcl1_tb.sv

/* Makefile */
# build and run the fcl1 testbench with verilator
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module fcl1_tb -f fcl1_top.f -o fcl1_sim
	./obj_dir/fcl1_sim > sim.log
	cat sim.log
	! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
